// File: design/pipe_pkg.sv
/*
 * pipe_pkg
 * Shared widths, operation codes and data memory size for the
 * four-stage forwarding pipeline.
 */

package pipe_pkg;

    // data path and register index widths
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [11:0] imm_t;

    // operations accepted on the issue port
    typedef enum logic [2:0] {
        OP_NOP  = 3'd0,
        OP_ADD  = 3'd1,
        OP_SUB  = 3'd2,
        OP_AND  = 3'd3,
        OP_XOR  = 3'd4,
        OP_ADDI = 3'd5,
        OP_LW   = 3'd6,
        OP_SW   = 3'd7
    } op_e;

    localparam int GPR_COUNT = 32;

    // data memory, word addressed from byte address bits 7:2
    localparam int MEM_WORDS = 64;
    typedef logic [5:0] mem_addr_t;

endpackage

// File: design/gpr_file.sv
/*
 * gpr_file
 * 32 x 32 register file, two asynchronous read ports and one
 * synchronous write port. x0 always reads as zero.
 */

`timescale 1ns/1ns

module gpr_file (
    input  logic              clk,
    input  logic              rst_n,
    input  pipe_pkg::reg_idx_t rs1_addr,
    input  pipe_pkg::reg_idx_t rs2_addr,
    input  logic              we,
    input  pipe_pkg::reg_idx_t waddr,
    input  pipe_pkg::word_t   wdata,
    output pipe_pkg::word_t   rs1_data,
    output pipe_pkg::word_t   rs2_data
);

    pipe_pkg::word_t regs [pipe_pkg::GPR_COUNT];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < pipe_pkg::GPR_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 is never stored, so mask it on read
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// File: design/issue_decode.sv
/*
 * issue_decode
 * Decode and issue stage. Derives the control fields, reads the
 * register file with WB forwarding and holds the ID/EX register.
 */

`timescale 1ns/1ns

module issue_decode (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               issue_valid,
    input  pipe_pkg::op_e      issue_op,
    input  pipe_pkg::reg_idx_t issue_rd,
    input  pipe_pkg::reg_idx_t issue_rs1,
    input  pipe_pkg::reg_idx_t issue_rs2,
    input  pipe_pkg::imm_t     issue_imm,
    input  pipe_pkg::word_t    rd1_data,
    input  pipe_pkg::word_t    rd2_data,
    input  logic               id_fwd_rs1,
    input  logic               id_fwd_rs2,
    input  pipe_pkg::word_t    wb_fwd_data,
    output pipe_pkg::reg_idx_t id_rs1,
    output pipe_pkg::reg_idx_t id_rs2,
    output logic               ex_valid,
    output pipe_pkg::op_e      ex_op,
    output pipe_pkg::reg_idx_t ex_rd,
    output pipe_pkg::reg_idx_t ex_rs1,
    output pipe_pkg::reg_idx_t ex_rs2,
    output pipe_pkg::word_t    ex_a,
    output pipe_pkg::word_t    ex_b,
    output pipe_pkg::word_t    ex_imm,
    output logic               ex_write_gpr,
    output logic               ex_mem_to_reg,
    output logic               ex_mem_write
);

    logic            writes_rd;
    logic            id_write_gpr;
    pipe_pkg::word_t id_a;
    pipe_pkg::word_t id_b;

    // ops that produce a register result
    always_comb begin
        case (issue_op)
            pipe_pkg::OP_ADD, pipe_pkg::OP_SUB, pipe_pkg::OP_AND,
            pipe_pkg::OP_XOR, pipe_pkg::OP_ADDI, pipe_pkg::OP_LW: writes_rd = 1'b1;
            default: writes_rd = 1'b0;
        endcase
    end

    // x0 is dropped here so no later stage has to test for it
    assign id_write_gpr = issue_valid & writes_rd & (issue_rd != '0);

    assign id_rs1 = issue_rs1;
    assign id_rs2 = issue_rs2;

    // WB writes this cycle, file still holds the old value
    assign id_a = id_fwd_rs1 ? wb_fwd_data : rd1_data;
    assign id_b = id_fwd_rs2 ? wb_fwd_data : rd2_data;

    // ========================================================================
    // ID/EX register
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid      <= 1'b0;
            ex_write_gpr  <= 1'b0;
            ex_mem_to_reg <= 1'b0;
            ex_mem_write  <= 1'b0;
        end else begin
            ex_valid      <= issue_valid;
            ex_write_gpr  <= id_write_gpr;
            ex_mem_to_reg <= issue_valid & (issue_op == pipe_pkg::OP_LW);
            ex_mem_write  <= issue_valid & (issue_op == pipe_pkg::OP_SW);
        end
    end

    always_ff @(posedge clk) begin
        ex_op  <= issue_op;
        ex_rd  <= issue_rd;
        ex_rs1 <= issue_rs1;
        ex_rs2 <= issue_rs2;
        ex_a   <= id_a;
        ex_b   <= id_b;
        ex_imm <= {{20{issue_imm[11]}}, issue_imm};
    end

endmodule

// File: design/hazard_forward.sv
/*
 * hazard_forward
 * Detects MEM and WB data hazards and selects forwarded operands
 * for the execute stage and for the ID/EX register.
 */

`timescale 1ns/1ns

module hazard_forward (
    input  pipe_pkg::reg_idx_t id_rs1,
    input  pipe_pkg::reg_idx_t id_rs2,
    input  pipe_pkg::reg_idx_t ex_rs1,
    input  pipe_pkg::reg_idx_t ex_rs2,
    input  pipe_pkg::reg_idx_t mem_rd,
    input  logic               mem_write_gpr,
    input  logic               mem_to_reg,
    input  pipe_pkg::word_t    mem_alu_out,
    input  pipe_pkg::word_t    mem_rdata,
    input  pipe_pkg::reg_idx_t wb_rd,
    input  logic               wb_write_gpr,
    input  pipe_pkg::word_t    wb_data,
    output logic               id_fwd_rs1,
    output logic               id_fwd_rs2,
    output pipe_pkg::word_t    wb_fwd_data,
    output logic               ex_fwd_rs1,
    output logic               ex_fwd_rs2,
    output pipe_pkg::word_t    ex_fwd_rs1_data,
    output pipe_pkg::word_t    ex_fwd_rs2_data
);

    // MEM stage result: load data or ALU output, MEM wins over WB
    function automatic pipe_pkg::word_t pick_ex_data(
        input logic            load_hit,
        input logic            alu_hit,
        input logic            wb_hit,
        input pipe_pkg::word_t load_data,
        input pipe_pkg::word_t alu_data,
        input pipe_pkg::word_t wb_value
    );
        pipe_pkg::word_t sel;
        sel = '0;
        if (load_hit) begin
            sel = load_data;
        end else if (alu_hit) begin
            sel = alu_data;
        end else if (wb_hit) begin
            sel = wb_value;
        end
        return sel;
    endfunction

    logic first_rs1, first_rs2;
    logic load_use_rs1, load_use_rs2;
    logic second_rs1, second_rs2;
    logic mem_hit_rs1, mem_hit_rs2;

    // write_gpr already excludes x0, no index-zero test needed
    assign mem_hit_rs1  = (ex_rs1 == mem_rd) & mem_write_gpr;
    assign mem_hit_rs2  = (ex_rs2 == mem_rd) & mem_write_gpr;

    // first stage: ALU result sitting in EX/MEM
    assign first_rs1    = mem_hit_rs1 & ~mem_to_reg;
    assign first_rs2    = mem_hit_rs2 & ~mem_to_reg;
    // load use: memory answers in the same cycle, just forward it
    assign load_use_rs1 = mem_hit_rs1 & mem_to_reg;
    assign load_use_rs2 = mem_hit_rs2 & mem_to_reg;
    // second stage: value in MEM/WB not yet written back
    assign second_rs1   = (ex_rs1 == wb_rd) & wb_write_gpr;
    assign second_rs2   = (ex_rs2 == wb_rd) & wb_write_gpr;

    assign ex_fwd_rs1 = first_rs1 | load_use_rs1 | second_rs1;
    assign ex_fwd_rs2 = first_rs2 | load_use_rs2 | second_rs2;

    assign ex_fwd_rs1_data = pick_ex_data(load_use_rs1, first_rs1, second_rs1,
                                          mem_rdata, mem_alu_out, wb_data);
    assign ex_fwd_rs2_data = pick_ex_data(load_use_rs2, first_rs2, second_rs2,
                                          mem_rdata, mem_alu_out, wb_data);

    // ========================================================================
    // third stage: decode reads while WB writes
    // ========================================================================
    assign id_fwd_rs1  = (id_rs1 == wb_rd) & wb_write_gpr;
    assign id_fwd_rs2  = (id_rs2 == wb_rd) & wb_write_gpr;
    assign wb_fwd_data = wb_data;

endmodule

// File: design/execute_mem.sv
/*
 * execute_mem
 * Execute and memory stages: operand forwarding muxes, ALU,
 * EX/MEM register and the 64-word data memory.
 */

`timescale 1ns/1ns

module execute_mem (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               ex_valid,
    input  pipe_pkg::op_e      ex_op,
    input  pipe_pkg::reg_idx_t ex_rd,
    input  pipe_pkg::word_t    ex_a,
    input  pipe_pkg::word_t    ex_b,
    input  pipe_pkg::word_t    ex_imm,
    input  logic               ex_write_gpr,
    input  logic               ex_mem_to_reg,
    input  logic               ex_mem_write,
    input  logic               ex_fwd_rs1,
    input  logic               ex_fwd_rs2,
    input  pipe_pkg::word_t    ex_fwd_rs1_data,
    input  pipe_pkg::word_t    ex_fwd_rs2_data,
    output logic               mem_valid,
    output pipe_pkg::reg_idx_t mem_rd,
    output logic               mem_write_gpr,
    output logic               mem_to_reg,
    output pipe_pkg::word_t    mem_alu_out,
    output pipe_pkg::word_t    mem_rdata,
    output pipe_pkg::word_t    mem_result
);

    pipe_pkg::word_t    op_a;
    pipe_pkg::word_t    op_b;
    pipe_pkg::word_t    alu_b;
    pipe_pkg::word_t    alu_out;
    logic               mem_store;
    pipe_pkg::word_t    mem_wdata;
    pipe_pkg::mem_addr_t mem_addr;
    pipe_pkg::word_t    dmem [pipe_pkg::MEM_WORDS];

    // ========================================================================
    // execute
    // ========================================================================
    assign op_a = ex_fwd_rs1 ? ex_fwd_rs1_data : ex_a;
    assign op_b = ex_fwd_rs2 ? ex_fwd_rs2_data : ex_b;

    // addi, lw and sw take the immediate as second operand
    assign alu_b = ((ex_op == pipe_pkg::OP_ADDI) || (ex_op == pipe_pkg::OP_LW) ||
                    (ex_op == pipe_pkg::OP_SW)) ? ex_imm : op_b;

    always_comb begin
        case (ex_op)
            pipe_pkg::OP_SUB: alu_out = op_a - alu_b;
            pipe_pkg::OP_AND: alu_out = op_a & alu_b;
            pipe_pkg::OP_XOR: alu_out = op_a ^ alu_b;
            pipe_pkg::OP_NOP: alu_out = '0;
            default:          alu_out = op_a + alu_b;
        endcase
    end

    // EX/MEM register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_valid     <= 1'b0;
            mem_write_gpr <= 1'b0;
            mem_to_reg    <= 1'b0;
            mem_store     <= 1'b0;
        end else begin
            mem_valid     <= ex_valid;
            mem_write_gpr <= ex_write_gpr;
            mem_to_reg    <= ex_mem_to_reg;
            mem_store     <= ex_mem_write;
        end
    end

    // store data is the forwarded rs2 value
    always_ff @(posedge clk) begin
        mem_rd      <= ex_rd;
        mem_alu_out <= alu_out;
        mem_wdata   <= op_b;
    end

    // ========================================================================
    // memory
    // ========================================================================
    assign mem_addr = mem_alu_out[7:2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < pipe_pkg::MEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (mem_store) begin
            dmem[mem_addr] <= mem_wdata;
        end
    end

    // read answers in the same cycle
    assign mem_rdata  = dmem[mem_addr];
    assign mem_result = mem_to_reg ? mem_rdata : mem_alu_out;

endmodule

// File: design/writeback_stage.sv
/*
 * writeback_stage
 * Holds MEM/WB, drives the register file write port and the
 * retire strobe.
 */

`timescale 1ns/1ns

module writeback_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               mem_valid,
    input  pipe_pkg::reg_idx_t mem_rd,
    input  logic               mem_write_gpr,
    input  pipe_pkg::word_t    mem_result,
    output pipe_pkg::reg_idx_t wb_rd,
    output logic               wb_write_gpr,
    output pipe_pkg::word_t    wb_data,
    output logic               gpr_we,
    output logic               retire_valid,
    output pipe_pkg::reg_idx_t retire_rd,
    output pipe_pkg::word_t    retire_data
);

    logic wb_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid     <= 1'b0;
            wb_write_gpr <= 1'b0;
        end else begin
            wb_valid     <= mem_valid;
            wb_write_gpr <= mem_write_gpr;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd   <= mem_rd;
        wb_data <= mem_result;
    end

    // file write lands on the edge that ends this cycle
    assign gpr_we       = wb_valid & wb_write_gpr;
    assign retire_valid = wb_valid & wb_write_gpr;
    assign retire_rd    = wb_rd;
    assign retire_data  = wb_data;

endmodule

// File: design/fwd_pipe_top.sv
/*
 * fwd_pipe_top
 * Four-stage in-order pipeline with MEM/WB forwarding.
 */

`timescale 1ns/1ns

module fwd_pipe_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               issue_valid,
    input  pipe_pkg::op_e      issue_op,
    input  pipe_pkg::reg_idx_t issue_rd,
    input  pipe_pkg::reg_idx_t issue_rs1,
    input  pipe_pkg::reg_idx_t issue_rs2,
    input  pipe_pkg::imm_t     issue_imm,
    output logic               retire_valid,
    output pipe_pkg::reg_idx_t retire_rd,
    output pipe_pkg::word_t    retire_data
);

    pipe_pkg::reg_idx_t id_rs1, id_rs2;
    pipe_pkg::word_t    rd1_data, rd2_data;
    logic               id_fwd_rs1, id_fwd_rs2;
    pipe_pkg::word_t    wb_fwd_data;

    logic               ex_valid, ex_write_gpr, ex_mem_to_reg, ex_mem_write;
    pipe_pkg::op_e      ex_op;
    pipe_pkg::reg_idx_t ex_rd, ex_rs1, ex_rs2;
    pipe_pkg::word_t    ex_a, ex_b, ex_imm;
    logic               ex_fwd_rs1, ex_fwd_rs2;
    pipe_pkg::word_t    ex_fwd_rs1_data, ex_fwd_rs2_data;

    logic               mem_valid, mem_write_gpr, mem_to_reg;
    pipe_pkg::reg_idx_t mem_rd;
    pipe_pkg::word_t    mem_alu_out, mem_rdata, mem_result;

    pipe_pkg::reg_idx_t wb_rd;
    logic               wb_write_gpr, gpr_we;
    pipe_pkg::word_t    wb_data;

    issue_decode u_issue_decode (
        .clk(clk), .rst_n(rst_n),
        .issue_valid(issue_valid), .issue_op(issue_op), .issue_rd(issue_rd),
        .issue_rs1(issue_rs1), .issue_rs2(issue_rs2), .issue_imm(issue_imm),
        .rd1_data(rd1_data), .rd2_data(rd2_data),
        .id_fwd_rs1(id_fwd_rs1), .id_fwd_rs2(id_fwd_rs2), .wb_fwd_data(wb_fwd_data),
        .id_rs1(id_rs1), .id_rs2(id_rs2),
        .ex_valid(ex_valid), .ex_op(ex_op), .ex_rd(ex_rd),
        .ex_rs1(ex_rs1), .ex_rs2(ex_rs2),
        .ex_a(ex_a), .ex_b(ex_b), .ex_imm(ex_imm),
        .ex_write_gpr(ex_write_gpr), .ex_mem_to_reg(ex_mem_to_reg),
        .ex_mem_write(ex_mem_write)
    );

    gpr_file u_gpr_file (
        .clk(clk), .rst_n(rst_n),
        .rs1_addr(id_rs1), .rs2_addr(id_rs2),
        .we(gpr_we), .waddr(wb_rd), .wdata(wb_data),
        .rs1_data(rd1_data), .rs2_data(rd2_data)
    );

    hazard_forward u_hazard_forward (
        .id_rs1(id_rs1), .id_rs2(id_rs2), .ex_rs1(ex_rs1), .ex_rs2(ex_rs2),
        .mem_rd(mem_rd), .mem_write_gpr(mem_write_gpr), .mem_to_reg(mem_to_reg),
        .mem_alu_out(mem_alu_out), .mem_rdata(mem_rdata),
        .wb_rd(wb_rd), .wb_write_gpr(wb_write_gpr), .wb_data(wb_data),
        .id_fwd_rs1(id_fwd_rs1), .id_fwd_rs2(id_fwd_rs2), .wb_fwd_data(wb_fwd_data),
        .ex_fwd_rs1(ex_fwd_rs1), .ex_fwd_rs2(ex_fwd_rs2),
        .ex_fwd_rs1_data(ex_fwd_rs1_data), .ex_fwd_rs2_data(ex_fwd_rs2_data)
    );

    execute_mem u_execute_mem (
        .clk(clk), .rst_n(rst_n),
        .ex_valid(ex_valid), .ex_op(ex_op), .ex_rd(ex_rd),
        .ex_a(ex_a), .ex_b(ex_b), .ex_imm(ex_imm),
        .ex_write_gpr(ex_write_gpr), .ex_mem_to_reg(ex_mem_to_reg),
        .ex_mem_write(ex_mem_write),
        .ex_fwd_rs1(ex_fwd_rs1), .ex_fwd_rs2(ex_fwd_rs2),
        .ex_fwd_rs1_data(ex_fwd_rs1_data), .ex_fwd_rs2_data(ex_fwd_rs2_data),
        .mem_valid(mem_valid), .mem_rd(mem_rd), .mem_write_gpr(mem_write_gpr),
        .mem_to_reg(mem_to_reg), .mem_alu_out(mem_alu_out),
        .mem_rdata(mem_rdata), .mem_result(mem_result)
    );

    writeback_stage u_writeback_stage (
        .clk(clk), .rst_n(rst_n),
        .mem_valid(mem_valid), .mem_rd(mem_rd), .mem_write_gpr(mem_write_gpr),
        .mem_result(mem_result),
        .wb_rd(wb_rd), .wb_write_gpr(wb_write_gpr), .wb_data(wb_data),
        .gpr_we(gpr_we), .retire_valid(retire_valid),
        .retire_rd(retire_rd), .retire_data(retire_data)
    );

endmodule

// File: verification/fwd_pipe_tb.sv
/*
 * fwd_pipe_tb
 * Testbench for the forwarding pipeline. Replays the instruction stream
 * from the test data file and checks every retire against the
 * sequential result.
 */

`timescale 1ns/1ns

module fwd_pipe_tb;

    localparam int MAX_TESTS = 16;

    logic               clk;
    logic               rst_n;
    logic               issue_valid;
    pipe_pkg::op_e      issue_op;
    pipe_pkg::reg_idx_t issue_rd;
    pipe_pkg::reg_idx_t issue_rs1;
    pipe_pkg::reg_idx_t issue_rs2;
    pipe_pkg::imm_t     issue_imm;
    logic               retire_valid;
    pipe_pkg::reg_idx_t retire_rd;
    pipe_pkg::word_t    retire_data;

    // instruction stream as read from the file
    int                 line_id [$];
    logic               line_valid [$];
    pipe_pkg::op_e      line_op [$];
    pipe_pkg::reg_idx_t line_rd [$];
    pipe_pkg::reg_idx_t line_rs1 [$];
    pipe_pkg::reg_idx_t line_rs2 [$];
    pipe_pkg::imm_t     line_imm [$];
    pipe_pkg::word_t    line_exp [$];

    // retires still owed by the DUT, in issue order
    pipe_pkg::reg_idx_t exp_rd_q [$];
    pipe_pkg::word_t    exp_data_q [$];
    int                 exp_id_q [$];

    int   test_left [MAX_TESTS];
    int   test_errors [MAX_TESTS];
    int   error_count = 0;
    int   check_count = 0;
    int   tests_done = 0;
    int   cycle_count = 0;
    logic issued_any = 1'b0;
    logic lines_loaded = 1'b0;
    bit   load_ok;

    fwd_pipe_top u_fwd_pipe_top (
        .clk(clk), .rst_n(rst_n),
        .issue_valid(issue_valid), .issue_op(issue_op), .issue_rd(issue_rd),
        .issue_rs1(issue_rs1), .issue_rs2(issue_rs2), .issue_imm(issue_imm),
        .retire_valid(retire_valid), .retire_rd(retire_rd), .retire_data(retire_data)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // ALU ops and loads write rd, x0 never counts
    function automatic bit writes_register(input logic valid, input pipe_pkg::op_e op,
                                           input pipe_pkg::reg_idx_t rd);
        bit result;
        result = 1'b0;
        case (op)
            pipe_pkg::OP_ADD, pipe_pkg::OP_SUB, pipe_pkg::OP_AND,
            pipe_pkg::OP_XOR, pipe_pkg::OP_ADDI, pipe_pkg::OP_LW: result = 1'b1;
            default: result = 1'b0;
        endcase
        return valid && result && (rd != '0);
    endfunction

    function automatic string test_label(input int tid);
        case (tid)
            1: return "reset_reads";
            2: return "independent_alu";
            3: return "back_to_back";
            4: return "distance_three";
            5: return "memory";
            default: return $sformatf("test_%0d", tid);
        endcase
    endfunction

    task automatic compare_value(input int tid, input string what,
                                 input logic [31:0] expected, input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            $display("mismatch %s %s: expected %08h, actual %08h",
                     test_label(tid), what, expected, actual);
            error_count++;
            test_errors[tid]++;
        end
    endtask

    // ========================================================================
    // test data
    // ========================================================================
    task automatic load_testdata(output bit ok);
        int          fd;
        int          got;
        string       text;
        int          id_v, valid_v, op_v, rd_v, rs1_v, rs2_v;
        logic [31:0] imm_v;
        logic [31:0] exp_v;
        pipe_pkg::op_e op_t;
        ok = 1'b1;
        fd = $fopen("verification/fwd_pipe_testdata.txt", "r");
        if (fd == 0) begin
            $display("cannot open verification/fwd_pipe_testdata.txt");
            ok = 1'b0;
        end else begin
            while ($fgets(text, fd) != 0) begin
                // comment and blank lines
                if (text.len() == 0 || text[0] == "#" || text[0] == "\n") begin
                    continue;
                end
                got = $sscanf(text, "%d %d %d %d %d %d %h %h", id_v, valid_v, op_v,
                              rd_v, rs1_v, rs2_v, imm_v, exp_v);
                if (got != 8 || id_v < 1 || id_v >= MAX_TESTS) begin
                    $display("malformed line in test data: %s", text);
                    ok = 1'b0;
                end else begin
                    op_t = pipe_pkg::op_e'(op_v[2:0]);
                    line_id.push_back(id_v);
                    line_valid.push_back(valid_v[0]);
                    line_op.push_back(op_t);
                    line_rd.push_back(rd_v[4:0]);
                    line_rs1.push_back(rs1_v[4:0]);
                    line_rs2.push_back(rs2_v[4:0]);
                    line_imm.push_back(imm_v[11:0]);
                    line_exp.push_back(exp_v);
                    if (writes_register(valid_v[0], op_t, rd_v[4:0])) begin
                        test_left[id_v]++;
                    end
                end
            end
            $fclose(fd);
            if (line_id.size() == 0) begin
                $display("test data file holds no instructions");
                ok = 1'b0;
            end
        end
    endtask

    // one line per cycle, shortly after the rising edge
    task automatic drive_lines();
        for (int i = 0; i < line_id.size(); i++) begin
            @(posedge clk);
            #1;
            issue_valid = line_valid[i];
            issue_op    = line_op[i];
            issue_rd    = line_rd[i];
            issue_rs1   = line_rs1[i];
            issue_rs2   = line_rs2[i];
            issue_imm   = line_imm[i];
            if (line_valid[i]) begin
                issued_any = 1'b1;
            end
            if (writes_register(line_valid[i], line_op[i], line_rd[i])) begin
                exp_rd_q.push_back(line_rd[i]);
                exp_data_q.push_back(line_exp[i]);
                exp_id_q.push_back(line_id[i]);
            end
        end
        @(posedge clk);
        #1;
        issue_valid = 1'b0;
    endtask

    // ========================================================================
    // retire checking, sampled away from the active edge
    // ========================================================================
    always @(negedge clk) begin : retire_check
        int                 tid;
        pipe_pkg::reg_idx_t want_rd;
        pipe_pkg::word_t    want_data;
        if (retire_valid) begin
            if (!issued_any) begin
                $display("retire_valid went high before any instruction was issued");
                error_count++;
            end else if (exp_rd_q.size() == 0) begin
                $display("retire of x%0d seen with no instruction outstanding", retire_rd);
                error_count++;
            end else begin
                tid       = exp_id_q.pop_front();
                want_rd   = exp_rd_q.pop_front();
                want_data = exp_data_q.pop_front();
                compare_value(tid, "rd", 32'(want_rd), 32'(retire_rd));
                compare_value(tid, "data", want_data, retire_data);
                test_left[tid]--;
                if (test_left[tid] == 0) begin
                    $display("test %0d %s done, %0d errors", tid, test_label(tid),
                             test_errors[tid]);
                    tests_done++;
                end
            end
        end
    end

    initial begin : watchdog
        int limit;
        wait (lines_loaded);
        limit = 4 * line_id.size() + 50;
        while (cycle_count < limit) begin
            @(posedge clk);
        end
        $display("timeout after %0d cycles, %0d retires never seen", limit, exp_rd_q.size());
        for (int i = 0; i < exp_rd_q.size(); i++) begin
            $display("  outstanding %s x%0d expected %08h", test_label(exp_id_q[i]),
                     exp_rd_q[i], exp_data_q[i]);
        end
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin : main_flow
        rst_n       = 1'b0;
        issue_valid = 1'b0;
        issue_op    = pipe_pkg::OP_NOP;
        issue_rd    = '0;
        issue_rs1   = '0;
        issue_rs2   = '0;
        issue_imm   = '0;
        load_testdata(load_ok);
        if (!load_ok) begin
            $display("test data could not be read, run stopped");
            $display("ERRORS FOUND");
            $finish;
        end else begin
            lines_loaded = 1'b1;
            repeat (8) @(posedge clk);
            #1;
            rst_n = 1'b1;
            drive_lines();
            while (exp_rd_q.size() != 0) begin
                @(posedge clk);
            end
            // catch late retires that nobody asked for
            repeat (4) @(posedge clk);
            $display("%0d tests, %0d checks, %0d errors", tests_done, check_count,
                     error_count);
            if (error_count == 0) begin
                $display("NO ERRORS");
            end else begin
                $display("ERRORS FOUND");
            end
            $finish;
        end
    end

endmodule

// File: verification/fwd_pipe_testdata.txt
# test_id valid op rd rs1 rs2 imm(hex) expected(hex)
# op: 0 nop, 1 add, 2 sub, 3 and, 4 xor, 5 addi, 6 lw, 7 sw
1 1 1  5  6  7 000 00000000
1 1 4  8  9 10 000 00000000
1 0 0  0  0  0 000 00000000
2 1 5  1  0  0 064 00000064
2 1 5  2  0  0 ff3 fffffff3
2 0 0  0  0  0 000 00000000
2 0 0  0  0  0 000 00000000
2 0 0  0  0  0 000 00000000
2 1 1  3  1  2 000 00000057
2 0 0  0  0  0 000 00000000
2 1 2  4  1  2 000 00000071
2 0 0  0  0  0 000 00000000
2 1 3  5  1  2 000 00000060
2 0 0  0  0  0 000 00000000
2 1 4  6  1  2 000 ffffff97
2 0 0  0  0  0 000 00000000
3 1 5  7  0  0 00a 0000000a
3 1 1  8  7  7 000 00000014
3 1 2  9  8  7 000 0000000a
3 1 5  9  9  0 003 0000000d
3 1 1 10  9  8 000 00000021
3 0 0  0  0  0 000 00000000
4 1 5 11  0  0 07b 0000007b
4 0 0  0  0  0 000 00000000
4 0 0  0  0  0 000 00000000
4 1 5 12 11  0 001 0000007c
4 1 5  0 11  0 055 00000000
4 1 1 13  0  0 000 00000000
4 0 0  0  0  0 000 00000000
4 1 1 14  0 11 000 0000007b
5 1 5 15  0  0 5a5 000005a5
5 1 5 16  0  0 010 00000010
5 1 7  0 16 15 004 00000000
5 1 6 17 16  0 004 000005a5
5 1 1 18 17 15 000 00000b4a
5 1 6 19  0  0 040 00000000
5 1 4 20 19 18 000 00000b4a
5 1 0  0  0  0 000 00000000

// File: build.f
design/pipe_pkg.sv
design/gpr_file.sv
design/issue_decode.sv
design/hazard_forward.sv
design/execute_mem.sv
design/writeback_stage.sv
design/fwd_pipe_top.sv
verification/fwd_pipe_tb.sv

// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"

test:
	verilator --binary --timing -f build.f --top-module fwd_pipe_tb -Mdir obj_dir
	./obj_dir/Vfwd_pipe_tb | tee $(LOG)
	@grep -qx "NO ERRORS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
